//--- rtl/dsp_pkg.sv
// Widths, types, FSM states and constants of the ADC/DAC datapath, imported by every RTL block
package dsp_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  localparam int ADC_IN_W = 16;  // ADC word as delivered by the converter
  localparam int DROP_LSB = 2;   // Reserved low bits of the 16-bit word
  localparam int SMP_W    = 14;  // Sample and DAC code width
  localparam int SUM_W    = 15;  // Generator + controller sum, one bit headroom
  localparam int AVG_LEN  = 64;  // Moving average window
  localparam int AVG_LOG2 = 6;   // Window depth as a shift
  localparam int ACC_W    = 20;  // Holds 64 full-scale raw codes

  //////////////////////////////////////////////////
  // Scalar types
  //////////////////////////////////////////////////

  typedef logic        [ADC_IN_W-1:0] adc_word_t;  // Raw pins of one ADC channel
  typedef logic        [SMP_W-1:0]    raw_code_t;  // Unsigned, negative slope
  typedef logic signed [SMP_W-1:0]    smp_t;       // Two's complement sample
  typedef logic signed [SUM_W-1:0]    sum_t;       // Unsaturated sum
  typedef logic        [SMP_W-1:0]    dac_code_t;  // Offset code, negative slope
  typedef logic        [ACC_W-1:0]    acc_t;       // Averager running sum
  typedef logic        [AVG_LOG2-1:0] avg_idx_t;   // Ring position

  //////////////////////////////////////////////////
  // Grouped signals
  //////////////////////////////////////////////////

  typedef struct packed {
    adc_word_t a;  // Channel A word
    adc_word_t b;  // Channel B word
  } adc_in_t;

  // Same layout for ADC, generator, controller and saturated sums
  typedef struct packed {
    smp_t a;
    smp_t b;
  } sample_pair_t;

  typedef struct packed {
    logic loop_en;    // DAC values looped back onto the ADC path
    logic avg_flush;  // Empty the averager window
  } cfg_t;

  // Configuration handshake states
  typedef enum logic [1:0] {
    CFG_IDLE,   // Waiting for a request
    CFG_APPLY,  // Request seen, register loads on the next edge
    CFG_ACK     // Ack held until the request drops
  } cfg_state_t;

  // Sign kept, magnitude bits inverted; works in both directions
  function automatic logic [SMP_W-1:0] slope_flip(input logic [SMP_W-1:0] v);
    slope_flip = {v[SMP_W-1], ~v[SMP_W-2:0]};
  endfunction

  // DAC code for a zero sample
  localparam dac_code_t DAC_ZERO = {1'b0, {(SMP_W-1){1'b1}}};

endpackage

//--- rtl/adc_frontend.sv
// ADC capture stage: registers both raw codes, converts to two's complement, muxes loopback
`timescale 1ns/1ns

module adc_frontend (
  input  logic                  adc_clk,     // ADC sample clock
  input  logic                  adc_rstn,    // Sync reset, active low
  input  dsp_pkg::adc_in_t      adc_i,       // Both ADC words
  input  logic                  loop_en_i,   // Digital loopback enable
  input  dsp_pkg::sample_pair_t loop_dat_i,  // Saturated DAC-side sums
  output dsp_pkg::raw_code_t    raw_b_o,     // Registered raw B code for the averager
  output dsp_pkg::sample_pair_t adc_o        // Samples toward scope and controller
);

  import dsp_pkg::*;

  //////////////////////////////////////////////////
  // Input registers
  //////////////////////////////////////////////////

  raw_code_t raw_a_q;  // Channel A, reserved bits stripped
  raw_code_t raw_b_q;  // Channel B, reserved bits stripped

  sample_pair_t conv;  // Converted ADC samples

  // Would map onto IOB flops on the board
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      raw_a_q <= '0;
      raw_b_q <= '0;
    end else begin
      raw_a_q <= adc_i.a[ADC_IN_W-1:DROP_LSB];  // Top 14 bits only
      raw_b_q <= adc_i.b[ADC_IN_W-1:DROP_LSB];
    end
  end

  //////////////////////////////////////////////////
  // Format conversion and loopback
  //////////////////////////////////////////////////

  // Negative slope offset code into two's complement
  always_comb begin
    conv.a = smp_t'(slope_flip(raw_a_q));
    conv.b = smp_t'(slope_flip(raw_b_q));
  end

  // Loopback is combinational from the mixer sums
  assign adc_o = loop_en_i ? loop_dat_i : conv;

  // Averager works on the unconverted code
  assign raw_b_o = raw_b_q;

endmodule

//--- rtl/dac_mixer.sv
// DAC side adder: sums generator and controller samples, saturates, registers channel A code
`timescale 1ns/1ns

module dac_mixer (
  input  logic                  adc_clk,   // ADC sample clock
  input  logic                  adc_rstn,  // Sync reset, active low
  input  dsp_pkg::sample_pair_t asg_i,     // Generator samples
  input  dsp_pkg::sample_pair_t pid_i,     // Controller samples
  output dsp_pkg::sample_pair_t sat_o,     // Saturated sums, combinational
  output dsp_pkg::dac_code_t    dac_a_o    // Channel A DAC code
);

  import dsp_pkg::*;

  //////////////////////////////////////////////////
  // Saturation
  //////////////////////////////////////////////////

  // Clamp to the 14-bit range when the two top bits disagree
  function automatic smp_t sat_smp(input sum_t s);
    if (s[SUM_W-1] ^ s[SUM_W-2]) begin
      sat_smp = {s[SUM_W-1], {(SMP_W-1){~s[SUM_W-1]}}};  // Full scale toward the sign
    end else begin
      sat_smp = s[SMP_W-1:0];  // Fits already
    end
  endfunction

  sum_t sum_a;  // Channel A, one bit headroom
  sum_t sum_b;  // Channel B, one bit headroom

  //////////////////////////////////////////////////
  // Adders
  //////////////////////////////////////////////////

  // Sign extended before the add so nothing wraps
  always_comb begin
    sum_a = sum_t'(asg_i.a) + sum_t'(pid_i.a);
    sum_b = sum_t'(asg_i.b) + sum_t'(pid_i.b);
  end

  always_comb begin
    sat_o.a = sat_smp(sum_a);
    sat_o.b = sat_smp(sum_b);
  end

  //////////////////////////////////////////////////
  // Channel A output register
  //////////////////////////////////////////////////

  // Two's complement back to offset, negative slope
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      dac_a_o <= DAC_ZERO;  // Mid scale
    end else begin
      dac_a_o <= dac_code_t'(slope_flip(sat_o.a));
    end
  end

  // Channel B sum only leaves through sat_o
  // The B DAC carries the moving average instead

endmodule

//--- rtl/moving_average.sv
// 64-sample moving average of the raw channel B code, driving the channel B DAC
`timescale 1ns/1ns

module moving_average (
  input  logic               adc_clk,   // ADC sample clock
  input  logic               adc_rstn,  // Sync reset, active low
  input  logic               flush_i,   // Empty the window
  input  dsp_pkg::raw_code_t raw_i,     // Newest registered raw B code
  output dsp_pkg::dac_code_t dac_b_o    // Window mean
);

  import dsp_pkg::*;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  raw_code_t ring_q [AVG_LEN];  // Last 64 raw codes
  avg_idx_t  idx_q;             // Slot of the oldest code
  acc_t      sum_q;             // Sum over the whole ring

  raw_code_t old_code;          // Code about to be replaced
  acc_t      sum_next;          // Sum after this edge

  assign old_code = ring_q[idx_q];

  // Add newest, drop oldest
  // Never underflows since old_code is part of sum_q
  assign sum_next = sum_q + acc_t'(raw_i) - acc_t'(old_code);

  //////////////////////////////////////////////////
  // Ring, sum and output
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      for (int k = 0; k < AVG_LEN; k++) begin
        ring_q[k] <= '0;
      end
      idx_q   <= '0;
      sum_q   <= '0;
      dac_b_o <= DAC_ZERO;  // Offset code of zero, like channel A
    end else if (flush_i) begin
      // Window starts from all zeros
      for (int k = 0; k < AVG_LEN; k++) begin
        ring_q[k] <= '0;
      end
      idx_q   <= '0;
      sum_q   <= '0;
      dac_b_o <= '0;  // Empty window averages to code 0
    end else begin
      ring_q[idx_q] <= raw_i;                  // Overwrite oldest
      idx_q         <= idx_q + avg_idx_t'(1);  // Wraps after slot 63
      sum_q         <= sum_next;
      // Previous sum divided by the window, top 14 bits
      dac_b_o       <= dac_code_t'(sum_q >> AVG_LOG2);
    end
  end

  // Latency from raw_i to dac_b_o is two edges
  // One into sum_q, one into the output register

endmodule

//--- rtl/cfg_ctrl.sv
// Four-phase req/ack configuration port; holds the loopback setting and strobes averager flush
`timescale 1ns/1ns

module cfg_ctrl (
  input  logic          adc_clk,    // ADC sample clock
  input  logic          adc_rstn,   // Sync reset, active low
  input  logic          cfg_req_i,  // Request, held until ack
  input  dsp_pkg::cfg_t cfg_i,      // Stable while cfg_req_i is high
  output logic          cfg_ack_o,  // Ack, drops after the request drops
  output logic          loop_en_o,  // Current loopback setting
  output logic          flush_o     // One cycle averager clear
);

  import dsp_pkg::*;

  //////////////////////////////////////////////////
  // State
  //////////////////////////////////////////////////

  cfg_state_t state_q;  // Handshake phase
  cfg_state_t state_d;
  cfg_t       cfg_q;    // Configuration register

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      CFG_IDLE: begin
        if (cfg_req_i) begin
          state_d = CFG_APPLY;  // Request sampled high
        end
      end
      CFG_APPLY: begin
        state_d = CFG_ACK;  // Always one cycle
      end
      CFG_ACK: begin
        if (!cfg_req_i) begin
          state_d = CFG_IDLE;  // Requester released
        end
      end
      default: begin
        state_d = CFG_IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      state_q <= CFG_IDLE;
      cfg_q   <= '0;  // Loopback off, no flush
    end else begin
      state_q <= state_d;
      if (state_q == CFG_APPLY) begin
        cfg_q <= cfg_i;  // Loaded together with the ack rising
      end else if (state_q == CFG_ACK) begin
        cfg_q.avg_flush <= 1'b0;  // Flush bit is a strobe
      end
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  assign cfg_ack_o = (state_q == CFG_ACK);  // High for the whole ack phase
  assign loop_en_o = cfg_q.loop_en;         // Held until the next request
  assign flush_o   = cfg_q.avg_flush;       // First ack cycle only

endmodule

//--- rtl/analog_top.sv
// Analog datapath top: ADC front end, DAC mixer, channel B averager and configuration port
`timescale 1ns/1ns

module analog_top (
  // Clock and reset
  input  logic                  adc_clk,    // ADC sample clock
  input  logic                  adc_rstn,   // Sync reset, active low
  // ADC
  input  dsp_pkg::adc_in_t      adc_i,      // Raw ADC words, both channels
  output dsp_pkg::sample_pair_t adc_o,      // Converted or looped back samples
  // Generator and controller
  input  dsp_pkg::sample_pair_t asg_i,      // Generator samples
  input  dsp_pkg::sample_pair_t pid_i,      // Controller samples
  // DAC
  output dsp_pkg::dac_code_t    dac_a_o,    // Channel A, saturated sum
  output dsp_pkg::dac_code_t    dac_b_o,    // Channel B, moving average
  // Configuration
  input  logic                  cfg_req_i,  // Handshake request
  input  dsp_pkg::cfg_t         cfg_i,      // Requested configuration
  output logic                  cfg_ack_o   // Handshake ack
);

  import dsp_pkg::*;

  //////////////////////////////////////////////////
  // Local signals
  //////////////////////////////////////////////////

  sample_pair_t sat;      // Mixer sums, also the loopback source
  raw_code_t    raw_b;    // Registered raw B code
  logic         loop_en;  // From the configuration register
  logic         flush;    // Averager clear strobe

  //////////////////////////////////////////////////
  // Configuration
  //////////////////////////////////////////////////

  cfg_ctrl i_cfg (
    .adc_clk   (adc_clk  ),
    .adc_rstn  (adc_rstn ),
    .cfg_req_i (cfg_req_i),
    .cfg_i     (cfg_i    ),
    .cfg_ack_o (cfg_ack_o),
    .loop_en_o (loop_en  ),
    .flush_o   (flush    )
  );

  //////////////////////////////////////////////////
  // ADC path
  //////////////////////////////////////////////////

  adc_frontend i_adc (
    .adc_clk    (adc_clk ),
    .adc_rstn   (adc_rstn),
    .adc_i      (adc_i   ),
    .loop_en_i  (loop_en ),
    .loop_dat_i (sat     ),  // DAC values back in
    .raw_b_o    (raw_b   ),
    .adc_o      (adc_o   )
  );

  //////////////////////////////////////////////////
  // DAC path
  //////////////////////////////////////////////////

  dac_mixer i_mix (
    .adc_clk  (adc_clk ),
    .adc_rstn (adc_rstn),
    .asg_i    (asg_i   ),
    .pid_i    (pid_i   ),
    .sat_o    (sat     ),
    .dac_a_o  (dac_a_o )
  );

  // Channel B DAC shows the raw B mean
  moving_average i_avg (
    .adc_clk  (adc_clk ),
    .adc_rstn (adc_rstn),
    .flush_i  (flush   ),
    .raw_i    (raw_b   ),
    .dac_b_o  (dac_b_o )
  );

endmodule

//--- verif/analog_top_asserts.sv
// Concurrent checks on the configuration handshake, bound into cfg_ctrl of the analog top
`timescale 1ns/1ns

module analog_top_asserts (
  input logic adc_clk,    // ADC sample clock
  input logic adc_rstn,   // Sync reset, active low
  input logic cfg_req_i,  // Handshake request
  input logic cfg_ack_i,  // Handshake ack from the FSM
  input logic flush_i     // Averager clear strobe
);

  int unsigned fail_cnt = 0;  // Failed assertions so far

  //////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////

  // Reset edge leaves the ack low
  ack_low_in_reset: assert property (@(posedge adc_clk) !adc_rstn |=> !cfg_ack_i)
    else begin
      $error("cfg_ack_o high after a reset edge");
      fail_cnt++;
    end

  // Ack only answers a request seen on the edge that raised it
  ack_needs_req: assert property (@(posedge adc_clk) disable iff (!adc_rstn)
    $rose(cfg_ack_i) |-> $past(cfg_req_i))
    else begin
      $error("cfg_ack_o rose without cfg_req_i");
      fail_cnt++;
    end

  ack_held: assert property (@(posedge adc_clk) disable iff (!adc_rstn)
    cfg_ack_i && cfg_req_i |=> cfg_ack_i)  // No early release
    else begin
      $error("cfg_ack_o dropped while cfg_req_i high");
      fail_cnt++;
    end

  // Flush is a single cycle strobe
  flush_one_cycle: assert property (@(posedge adc_clk) disable iff (!adc_rstn)
    flush_i |=> !flush_i)
    else begin
      $error("flush strobe longer than one cycle");
      fail_cnt++;
    end

endmodule

bind cfg_ctrl analog_top_asserts cfg_asserts_i (
  .adc_clk   (adc_clk  ),
  .adc_rstn  (adc_rstn ),
  .cfg_req_i (cfg_req_i),
  .cfg_ack_i (cfg_ack_o),
  .flush_i   (flush_o  )
);

//--- verif/tb_analog_top.sv
// Testbench for analog_top: random stimulus on falling edges, checked against a cycle model
`timescale 1ns/1ns

module tb_analog_top;

  import dsp_pkg::*;

  //////////////////////////////////////////////////
  // Run length
  //////////////////////////////////////////////////

  localparam int     CLK_PERIOD = 100;
  localparam int     RST_CYCLES = 10;
  localparam int     N_CONV     = 200;  // Conversion only
  localparam int     N_SAT      = 200;  // Near-limit mixer inputs
  localparam int     N_AVG      = 400;  // Long averaging runs
  localparam int     N_LOOP     = 100;  // Loopback on, then off again
  localparam int     HS_MAX     = 10;   // Cycles allowed per handshake
  localparam int     N_HS       = 3;
  localparam int     TOTAL_CYC  = RST_CYCLES + N_CONV + N_SAT + 2 * N_AVG + 2 * N_LOOP
                                  + N_HS * HS_MAX;
  localparam longint WATCHDOG_NS = longint'(TOTAL_CYC + 200) * CLK_PERIOD;  // 200 spare
  localparam logic [31:0] SEED  = 32'h4fcb_7bb9;
  localparam int     SMP_MAX    = (1 << (SMP_W - 1)) - 1;  // 8191
  localparam int     SMP_MIN    = -(1 << (SMP_W - 1));     // -8192

  //////////////////////////////////////////////////
  // DUT
  //////////////////////////////////////////////////

  logic         adc_clk;
  logic         adc_rstn;
  adc_in_t      adc_i;
  sample_pair_t asg_i;
  sample_pair_t pid_i;
  logic         cfg_req_i;
  cfg_t         cfg_i;
  sample_pair_t adc_o;
  dac_code_t    dac_a_o;
  dac_code_t    dac_b_o;
  logic         cfg_ack_o;

  analog_top analog_top_i (
    .adc_clk   (adc_clk  ),
    .adc_rstn  (adc_rstn ),
    .adc_i     (adc_i    ),
    .adc_o     (adc_o    ),
    .asg_i     (asg_i    ),
    .pid_i     (pid_i    ),
    .dac_a_o   (dac_a_o  ),
    .dac_b_o   (dac_b_o  ),
    .cfg_req_i (cfg_req_i),
    .cfg_i     (cfg_i    ),
    .cfg_ack_o (cfg_ack_o)
  );

  initial begin
    adc_clk = 1'b0;
    forever #(CLK_PERIOD / 2) adc_clk = ~adc_clk;
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  raw_code_t m_raw_a;    // Raw codes as registered
  raw_code_t m_raw_b;
  raw_code_t hist[$];    // Up to 64 newest raw B codes
  dac_code_t m_dac_a;
  dac_code_t m_dac_b;
  logic      m_loop;     // Expected loopback setting
  logic      m_flush;    // Flush lands on the coming edge
  logic      hs_active;  // Handshake in progress
  logic      ack_seen;
  cfg_t      hs_cfg;     // Value being requested

  // Negative slope code into two's complement, sign kept
  function automatic smp_t conv_ref(raw_code_t r);
    return smp_t'(r ^ raw_code_t'(SMP_MAX));
  endfunction

  function automatic dac_code_t offset_ref(smp_t s);
    return dac_code_t'(s ^ smp_t'(SMP_MAX));  // Same rule back to offset code
  endfunction

  function automatic smp_t sat_ref(smp_t x, smp_t y);
    int s;
    s = int'(x) + int'(y);
    if (s > SMP_MAX) s = SMP_MAX;
    else if (s < SMP_MIN) s = SMP_MIN;
    return smp_t'(s);
  endfunction

  // Window sum recomputed from scratch
  function automatic int window_sum();
    int total;
    total = 0;
    foreach (hist[k]) total += int'(hist[k]);
    return total;
  endfunction

  function automatic smp_t rand_smp(bit near);
    int off;
    off = $urandom_range(3);
    if (!near || $urandom_range(1) == 0) return smp_t'($urandom);
    if ($urandom_range(1) == 1) return smp_t'(SMP_MAX - off);  // Just below full scale
    return smp_t'(SMP_MIN + off);
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic stop_on_error(string what);
    $display("%s", what);
    $display(">>> FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_sample(string name, sample_pair_t got, sample_pair_t exp);
    if (got !== exp)
      stop_on_error($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_dac(string name, dac_code_t got, dac_code_t exp);
    if (got !== exp)
      stop_on_error($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_ack(string name, logic got, logic exp);
    if (got !== exp)
      stop_on_error($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  //////////////////////////////////////////////////
  // Stimulus and stepping
  //////////////////////////////////////////////////

  task automatic drive_random(bit near);
    adc_i   = adc_in_t'($urandom);
    asg_i.a = rand_smp(near);
    asg_i.b = rand_smp(near);
    pid_i.a = rand_smp(near);
    pid_i.b = rand_smp(near);
  endtask

  // Model of the coming rising edge, from the inputs now driven
  task automatic advance_model();
    if (m_flush) begin
      hist.delete();  // Empty window
      m_dac_b = '0;
      m_flush = 1'b0;
    end else begin
      m_dac_b = dac_code_t'(window_sum() >> AVG_LOG2);  // Sum before this edge
      hist.push_back(m_raw_b);
      if (hist.size() > AVG_LEN) void'(hist.pop_front());
    end
    m_raw_a = adc_i.a[ADC_IN_W-1 -: SMP_W];  // Top 14 bits
    m_raw_b = adc_i.b[ADC_IN_W-1 -: SMP_W];
    m_dac_a = offset_ref(sat_ref(asg_i.a, pid_i.a));
  endtask

  task automatic step();
    sample_pair_t exp_adc;
    advance_model();
    @(negedge adc_clk);
    // New configuration visible once the ack is up
    if (hs_active && !ack_seen && cfg_ack_o === 1'b1) begin
      ack_seen = 1'b1;
      m_loop   = hs_cfg.loop_en;
      m_flush  = hs_cfg.avg_flush;
    end
    if (m_loop) begin
      exp_adc.a = sat_ref(asg_i.a, pid_i.a);  // Current inputs, combinational
      exp_adc.b = sat_ref(asg_i.b, pid_i.b);
    end else begin
      exp_adc.a = conv_ref(m_raw_a);
      exp_adc.b = conv_ref(m_raw_b);
    end
    check_sample("adc_o", adc_o, exp_adc);
    check_dac("dac_a_o", dac_a_o, m_dac_a);
    check_dac("dac_b_o", dac_b_o, m_dac_b);
    if (!hs_active) check_ack("cfg_ack_o", cfg_ack_o, 1'b0);
  endtask

  task automatic run_cycles(int n, bit near);
    repeat (n) begin
      drive_random(near);
      step();
    end
  endtask

  // Four-phase request, data keeps flowing meanwhile
  task automatic handshake(logic loop_en, logic flush);
    hs_cfg.loop_en   = loop_en;
    hs_cfg.avg_flush = flush;
    cfg_i     = hs_cfg;
    cfg_req_i = 1'b1;
    hs_active = 1'b1;
    ack_seen  = 1'b0;
    while (!ack_seen) begin
      drive_random(1'b0);
      step();
    end
    // Request still up for one more edge, ack has to stay
    drive_random(1'b0);
    step();
    check_ack("cfg_ack_o", cfg_ack_o, 1'b1);
    cfg_req_i = 1'b0;
    drive_random(1'b0);
    step();  // First edge with the request low
    check_ack("cfg_ack_o", cfg_ack_o, 1'b0);
    hs_active = 1'b0;
    cfg_i     = '0;
  endtask

  //////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////

  initial begin
    #(WATCHDOG_NS);
    stop_on_error("Timeout: the tests did not finish in the expected time");
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    sample_pair_t exp_rst;  // adc_o with both raw registers cleared
    void'($urandom(SEED));
    adc_rstn  = 1'b0;
    adc_i     = '0;
    asg_i     = '0;
    pid_i     = '0;
    cfg_req_i = 1'b0;
    cfg_i     = '0;
    m_raw_a   = '0;
    m_raw_b   = '0;
    hist.delete();
    m_dac_a   = offset_ref('0);  // Mid scale
    m_dac_b   = offset_ref('0);
    m_loop    = 1'b0;
    m_flush   = 1'b0;
    hs_active = 1'b0;
    ack_seen  = 1'b0;
    hs_cfg    = '0;
    repeat (RST_CYCLES) @(negedge adc_clk);

    // Outputs still held by reset
    exp_rst.a = conv_ref('0);
    exp_rst.b = conv_ref('0);
    check_sample("adc_o", adc_o, exp_rst);
    check_dac("dac_a_o", dac_a_o, m_dac_a);
    check_dac("dac_b_o", dac_b_o, m_dac_b);
    check_ack("cfg_ack_o", cfg_ack_o, 1'b0);
    adc_rstn = 1'b1;

    run_cycles(N_CONV, 1'b0);  // ADC conversion
    run_cycles(N_SAT, 1'b1);   // Saturation near both limits
    run_cycles(N_AVG, 1'b1);   // Full windows of averaging

    handshake(1'b1, 1'b0);     // Loopback on
    run_cycles(N_LOOP, 1'b1);
    handshake(1'b0, 1'b0);     // Loopback off
    run_cycles(N_LOOP, 1'b1);

    handshake(1'b0, 1'b1);     // Flush, window restarts
    check_dac("dac_b_o", dac_b_o, '0);
    run_cycles(N_AVG, 1'b1);

    if (analog_top_i.i_cfg.cfg_asserts_i.fail_cnt == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      stop_on_error("Handshake assertions failed during the run");
    end
  end

endmodule

//--- sources.f
rtl/dsp_pkg.sv
rtl/adc_frontend.sv
rtl/dac_mixer.sv
rtl/moving_average.sv
rtl/cfg_ctrl.sv
rtl/analog_top.sv
verif/analog_top_asserts.sv
verif/tb_analog_top.sv
